/* sources.f */
rtl/or1k_decode_pkg.sv
rtl/op_class_decode.sv
rtl/imm_gen.sv
rtl/illegal_check.sv
rtl/decode_ctrl.sv
rtl/decode_stage.sv
test/decode_assertions.sv
test/tb_decode_stage.sv

/* Makefile */
TOP = tb_decode_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

/* test/tb_decode_stage.sv */
module tb_decode_stage;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 5;
   localparam int N_LS         = 200;
   localparam int N_ALU        = 200;
   localparam int N_JMP        = 150;
   localparam int N_RND        = 300;
   localparam int N_SYS        = 60;
   localparam int N_LAT        = 150;
   localparam int N_WH         = or1k_decode_pkg::DS_CREDITS + 4;
   localparam int N_TOTAL      = N_LS + N_ALU + N_JMP + N_RND + N_SYS + N_LAT + N_WH;

   logic                         clk = 1'b0;
   logic                         arst_n_i = 1'b0;
   logic                         in_valid_i = 1'b0;
   or1k_decode_pkg::insn_t       insn_i = '0;
   logic                         credit_i = 1'b0;
   logic                         credit_o;
   logic                         out_valid_o;
   or1k_decode_pkg::decode_out_t out_o;

   integer                       seed = 32'he2aae31b;
   int                           cyc = 0;
   int                           errors = 0;
   int                           checks = 0;
   int                           tests = 0;
   int                           received = 0;
   int                           outstanding = 0;
   // 0 withholds credits, 1 returns at once, 2 returns after random delays
   int                           ret_mode = 0;
   logic                         fetch_credit = 1'b0;
   or1k_decode_pkg::insn_t       exp_q[$];
   int                           cyc_q[$];
   or1k_decode_pkg::opcode_t     pick_ops[$];
   or1k_decode_pkg::opcode_t     legal_ops[32];

   decode_stage i_decode_stage (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (in_valid_i),
      .insn_i      (insn_i),
      .credit_o    (credit_o),
      .out_valid_o (out_valid_o),
      .out_o       (out_o),
      .credit_i    (credit_i)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic or1k_decode_pkg::decode_out_t ref_decode(
      input or1k_decode_pkg::insn_t w);
      or1k_decode_pkg::decode_out_t r;
      or1k_decode_pkg::opcode_t     op;
      or1k_decode_pkg::alu_opc_t    mi;
      logic                         st;
      logic                         sext;
      logic                         zext;
      logic                         legal;
      logic [15:0]                  f;
      op = w[31:26];
      mi = w[3:0];
      r  = '0;
      st = op inside {or1k_decode_pkg::OPC_SW, or1k_decode_pkg::OPC_SB, or1k_decode_pkg::OPC_SH,
                      or1k_decode_pkg::OPC_SWA};
      r.opcode = op;
      r.rfa    = w[20:16];
      r.rfb    = w[15:11];
      r.flags.load = op inside {[or1k_decode_pkg::OPC_LWZ:or1k_decode_pkg::OPC_LHS],
                                or1k_decode_pkg::OPC_LWA};
      r.flags.store  = st;
      r.flags.atomic = op inside {or1k_decode_pkg::OPC_LWA, or1k_decode_pkg::OPC_SWA};
      r.flags.lsu_len = or1k_decode_pkg::LSU_WORD;
      if (op inside {or1k_decode_pkg::OPC_SB, or1k_decode_pkg::OPC_LBZ, or1k_decode_pkg::OPC_LBS}) begin
         r.flags.lsu_len = or1k_decode_pkg::LSU_BYTE;
      end
      if (op inside {or1k_decode_pkg::OPC_SH, or1k_decode_pkg::OPC_LHZ, or1k_decode_pkg::OPC_LHS}) begin
         r.flags.lsu_len = or1k_decode_pkg::LSU_HALF;
      end
      r.flags.lsu_zext = op[0];
      r.flags.jbr      = op < or1k_decode_pkg::OPC_NOP;
      r.flags.jr       = op inside {or1k_decode_pkg::OPC_JR, or1k_decode_pkg::OPC_JALR};
      r.flags.jal      = op inside {or1k_decode_pkg::OPC_JAL, or1k_decode_pkg::OPC_JALR};
      r.flags.bf       = op == or1k_decode_pkg::OPC_BF;
      r.flags.bnf      = op == or1k_decode_pkg::OPC_BNF;
      r.flags.branch   = r.flags.jbr || r.flags.jr || r.flags.jal;
      r.flags.alu = op inside {or1k_decode_pkg::OPC_ALU, or1k_decode_pkg::OPC_ORI,
                               or1k_decode_pkg::OPC_ANDI, or1k_decode_pkg::OPC_XORI};
      r.flags.setflag = op inside {or1k_decode_pkg::OPC_SF, or1k_decode_pkg::OPC_SFIMM};
      r.flags.mul = (op == or1k_decode_pkg::OPC_ALU &&
                     mi inside {or1k_decode_pkg::ALU_MUL, or1k_decode_pkg::ALU_MULU}) ||
                    op == or1k_decode_pkg::OPC_MULI;
      r.flags.div = op == or1k_decode_pkg::OPC_ALU &&
                    mi inside {or1k_decode_pkg::ALU_DIV, or1k_decode_pkg::ALU_DIVU};
      r.flags.shift = (op == or1k_decode_pkg::OPC_ALU && mi == or1k_decode_pkg::ALU_SHRT) ||
                      op == or1k_decode_pkg::OPC_SHRTI;
      r.flags.movhi = op == or1k_decode_pkg::OPC_MOVHI;
      r.flags.mfspr = op == or1k_decode_pkg::OPC_MFSPR;
      r.flags.mtspr = op == or1k_decode_pkg::OPC_MTSPR;
      r.flags.rfe   = op == or1k_decode_pkg::OPC_RFE;
      r.flags.rf_wb = r.flags.jal || r.flags.movhi || op == or1k_decode_pkg::OPC_LWA ||
                      (op[5:4] == 2'b10 && op != or1k_decode_pkg::OPC_SFIMM) ||
                      (op[5:4] == 2'b11 && !st &&
                       !(op inside {or1k_decode_pkg::OPC_SF, or1k_decode_pkg::OPC_MTSPR}));
      case (op)
         or1k_decode_pkg::OPC_ORI:  r.alu_opc = or1k_decode_pkg::ALU_OR;
         or1k_decode_pkg::OPC_ANDI: r.alu_opc = or1k_decode_pkg::ALU_AND;
         or1k_decode_pkg::OPC_XORI: r.alu_opc = or1k_decode_pkg::ALU_XOR;
         default:                   r.alu_opc = mi;
      endcase
      r.rfd = r.flags.jal ? or1k_decode_pkg::LINK_REG : w[25:21];
      // Immediate field, split for stores and mtspr
      f = (st || op == or1k_decode_pkg::OPC_MTSPR) ? {w[25:21], w[10:0]} : w[15:0];
      sext = (op[5:4] == 2'b10 &&
              !(op inside {or1k_decode_pkg::OPC_ORI, or1k_decode_pkg::OPC_ANDI})) ||
             st || op == or1k_decode_pkg::OPC_LWA;
      zext = op inside {or1k_decode_pkg::OPC_ORI, or1k_decode_pkg::OPC_ANDI,
                        or1k_decode_pkg::OPC_MTSPR};
      if (sext) begin
         r.imm.value = {{16{f[15]}}, f};
      end else if (zext) begin
         r.imm.value = {16'h0000, f};
      end else begin
         r.imm.value = {f, 16'h0000};
      end
      r.imm.sel = sext || zext || op == or1k_decode_pkg::OPC_MOVHI;
      r.exc.syscall = op == or1k_decode_pkg::OPC_SYSTRAPSYNC &&
                      w[25:21] == or1k_decode_pkg::SYS_SYSCALL;
      r.exc.trap    = op == or1k_decode_pkg::OPC_SYSTRAPSYNC &&
                      w[25:21] == or1k_decode_pkg::SYS_TRAP;
      legal = 1'b0;
      foreach (legal_ops[k]) begin
         if (legal_ops[k] == op) begin
            legal = 1'b1;
         end
      end
      if (op == or1k_decode_pkg::OPC_SHRTI) begin
         legal = w[7:6] != or1k_decode_pkg::SHRT_ROR;
      end
      if (op == or1k_decode_pkg::OPC_ALU) begin
         legal = (mi inside {or1k_decode_pkg::ALU_ADD, or1k_decode_pkg::ALU_SUB,
                             or1k_decode_pkg::ALU_AND, or1k_decode_pkg::ALU_OR,
                             or1k_decode_pkg::ALU_XOR, or1k_decode_pkg::ALU_MUL,
                             or1k_decode_pkg::ALU_MULU}) ||
                 (mi == or1k_decode_pkg::ALU_SHRT && w[7:6] != or1k_decode_pkg::SHRT_ROR);
      end
      if (op == or1k_decode_pkg::OPC_SYSTRAPSYNC) begin
         legal = w[25:21] inside {or1k_decode_pkg::SYS_SYSCALL, or1k_decode_pkg::SYS_TRAP,
                                  or1k_decode_pkg::SYS_MSYNC};
      end
      r.exc.illegal = !legal;
      return r;
   endfunction

   function automatic or1k_decode_pkg::insn_t make_insn();
      or1k_decode_pkg::insn_t w;
      w = $random(seed);
      if (pick_ops.size() != 0) begin
         w[31:26] = pick_ops[$unsigned($random(seed)) % pick_ops.size()];
      end
      // Steer about half of the SYSTRAPSYNC words onto defined sub-opcodes
      if (w[31:26] == or1k_decode_pkg::OPC_SYSTRAPSYNC && w[0]) begin
         case ($unsigned($random(seed)) % 3)
            0:       w[25:21] = or1k_decode_pkg::SYS_SYSCALL;
            1:       w[25:21] = or1k_decode_pkg::SYS_TRAP;
            default: w[25:21] = or1k_decode_pkg::SYS_MSYNC;
         endcase
      end
      return w;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_out(input or1k_decode_pkg::insn_t w, input int c);
      or1k_decode_pkg::decode_out_t exp;
      exp = ref_decode(w);
      checks++;
      if (out_o !== exp) begin
         $display("Fail at %0t: out_o got %h expected %h (insn %h)", $time, out_o, exp, w);
         errors++;
      end
      if (ret_mode == 1 && cyc - c != 2) begin
         $display("Fail at %0t: out_valid_o latency got %0d expected 2", $time, cyc - c);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err0);
      tests++;
      $display("Test %s finished with %0d errors", name, errors - err0);
   endtask

   // Downstream model, checks each output and hands credits back
   always @(negedge clk) begin
      or1k_decode_pkg::insn_t w;
      int                     c;
      credit_i = 1'b0;
      if (arst_n_i && out_valid_o) begin
         received++;
         outstanding++;
         if (exp_q.size() == 0) begin
            $display("Output at %0t arrived with no instruction in flight", $time);
            errors++;
         end else begin
            w = exp_q.pop_front();
            c = cyc_q.pop_front();
            check_out(w, c);
         end
         if (outstanding > or1k_decode_pkg::DS_CREDITS) begin
            $display("At %0t more outputs are outstanding than downstream credits", $time);
            errors++;
         end
      end
      if (outstanding > 0 &&
          (ret_mode == 1 || (ret_mode == 2 && ($random(seed) & 3) == 0))) begin
         credit_i = 1'b1;
         outstanding--;
      end
   end

   task automatic tick();
      @(negedge clk);
      in_valid_i = 1'b0;
      // Entry emptied, fetch has its credit back
      if (credit_o) begin
         fetch_credit = 1'b1;
      end
   endtask

   task automatic send_insn(input or1k_decode_pkg::insn_t w);
      tick();
      while (!fetch_credit || ($random(seed) & 3) == 0) begin
         tick();
      end
      in_valid_i   = 1'b1;
      insn_i       = w;
      fetch_credit = 1'b0;
      exp_q.push_back(w);
      cyc_q.push_back(cyc);
   endtask

   task automatic drain();
      while (exp_q.size() != 0 || outstanding != 0) begin
         tick();
      end
   endtask

   task automatic run_batch(input string name, input int n, input int mode);
      int err0;
      err0     = errors;
      ret_mode = mode;
      for (int i = 0; i < n; i++) begin
         send_insn(make_insn());
      end
      drain();
      report_test(name, err0);
   endtask

   task automatic run_withheld();
      int err0;
      int base;
      err0     = errors;
      base     = received;
      ret_mode = 0;
      // One more than the credits, the last one has to wait in the entry
      for (int i = 0; i <= or1k_decode_pkg::DS_CREDITS; i++) begin
         send_insn(make_insn());
      end
      repeat (30) tick();
      checks++;
      if (received - base != or1k_decode_pkg::DS_CREDITS) begin
         $display("With credits withheld %0d outputs appeared instead of %0d",
                  received - base, or1k_decode_pkg::DS_CREDITS);
         errors++;
      end
      if (exp_q.size() != 1) begin
         $display("With credits withheld %0d instructions wait instead of 1", exp_q.size());
         errors++;
      end
      ret_mode = 2;
      for (int i = 0; i < N_WH - or1k_decode_pkg::DS_CREDITS - 1; i++) begin
         send_insn(make_insn());
      end
      drain();
      report_test("credit_withheld", err0);
   endtask

   initial begin
      int err0;
      legal_ops = '{
         or1k_decode_pkg::OPC_J, or1k_decode_pkg::OPC_JAL, or1k_decode_pkg::OPC_BNF,
         or1k_decode_pkg::OPC_BF, or1k_decode_pkg::OPC_NOP, or1k_decode_pkg::OPC_MOVHI,
         or1k_decode_pkg::OPC_SYSTRAPSYNC, or1k_decode_pkg::OPC_RFE, or1k_decode_pkg::OPC_JR,
         or1k_decode_pkg::OPC_JALR, or1k_decode_pkg::OPC_LWA, or1k_decode_pkg::OPC_LWZ,
         or1k_decode_pkg::OPC_LWS, or1k_decode_pkg::OPC_LBZ, or1k_decode_pkg::OPC_LBS,
         or1k_decode_pkg::OPC_LHZ, or1k_decode_pkg::OPC_LHS, or1k_decode_pkg::OPC_ADDI,
         or1k_decode_pkg::OPC_ANDI, or1k_decode_pkg::OPC_ORI, or1k_decode_pkg::OPC_XORI,
         or1k_decode_pkg::OPC_MULI, or1k_decode_pkg::OPC_MFSPR, or1k_decode_pkg::OPC_SHRTI,
         or1k_decode_pkg::OPC_SFIMM, or1k_decode_pkg::OPC_MTSPR, or1k_decode_pkg::OPC_SWA,
         or1k_decode_pkg::OPC_SW, or1k_decode_pkg::OPC_SB, or1k_decode_pkg::OPC_SH,
         or1k_decode_pkg::OPC_ALU, or1k_decode_pkg::OPC_SF};

      // Outputs must stay quiet through reset and just after it
      err0 = errors;
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_bit("out_valid_o", out_valid_o, 1'b0);
         check_bit("credit_o", credit_o, 1'b0);
      end
      arst_n_i     = 1'b1;
      fetch_credit = 1'b1;
      repeat (2) begin
         tick();
         check_bit("out_valid_o", out_valid_o, 1'b0);
         check_bit("credit_o", credit_o, 1'b0);
      end
      report_test("reset", err0);

      pick_ops = {or1k_decode_pkg::OPC_LWA, or1k_decode_pkg::OPC_LWZ, or1k_decode_pkg::OPC_LWS,
                  or1k_decode_pkg::OPC_LBZ, or1k_decode_pkg::OPC_LBS, or1k_decode_pkg::OPC_LHZ,
                  or1k_decode_pkg::OPC_LHS, or1k_decode_pkg::OPC_SWA, or1k_decode_pkg::OPC_SW,
                  or1k_decode_pkg::OPC_SB, or1k_decode_pkg::OPC_SH};
      run_batch("loads_stores", N_LS, 2);

      pick_ops = {or1k_decode_pkg::OPC_ALU, or1k_decode_pkg::OPC_ADDI, or1k_decode_pkg::OPC_ANDI,
                  or1k_decode_pkg::OPC_ORI, or1k_decode_pkg::OPC_XORI, or1k_decode_pkg::OPC_MULI,
                  or1k_decode_pkg::OPC_SHRTI, or1k_decode_pkg::OPC_MOVHI, or1k_decode_pkg::OPC_SF,
                  or1k_decode_pkg::OPC_SFIMM, or1k_decode_pkg::OPC_MFSPR,
                  or1k_decode_pkg::OPC_MTSPR};
      run_batch("alu_immediate", N_ALU, 2);

      pick_ops = {or1k_decode_pkg::OPC_J, or1k_decode_pkg::OPC_JAL, or1k_decode_pkg::OPC_BNF,
                  or1k_decode_pkg::OPC_BF, or1k_decode_pkg::OPC_NOP, or1k_decode_pkg::OPC_JR,
                  or1k_decode_pkg::OPC_JALR, or1k_decode_pkg::OPC_RFE};
      run_batch("jumps_branches", N_JMP, 1);

      pick_ops.delete();
      run_batch("random_words", N_RND, 2);

      pick_ops = {or1k_decode_pkg::OPC_SYSTRAPSYNC};
      run_batch("systrapsync", N_SYS, 1);

      pick_ops.delete();
      foreach (legal_ops[k]) begin
         pick_ops.push_back(legal_ops[k]);
      end
      run_batch("latency", N_LAT, 1);
      run_withheld();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog, 40 cycles per instruction plus room for reset and idle stretches
   initial begin
      #(N_TOTAL * 40 * CLK_PERIOD + 200 * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* test/decode_assertions.sv */
module decode_assertions (
   input logic                         clk,
   input logic                         arst_n_i,
   input or1k_decode_pkg::credit_cnt_t credit_cnt,
   input logic                         out_valid_o,
   input logic                         credit_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Counter never climbs above the downstream buffer depth
   cnt_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
      credit_cnt <= or1k_decode_pkg::credit_cnt_t'(or1k_decode_pkg::DS_CREDITS))
      else $error("credit counter above downstream depth");

   // A send needs a credit in the cycle before
   valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
      out_valid_o |-> $past(credit_cnt) != '0)
      else $error("out_valid_o raised with no downstream credit");

   credit_with_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
      credit_o == out_valid_o)
      else $error("credit_o differs from out_valid_o");

endmodule

bind decode_ctrl decode_assertions i_decode_assertions (
   .clk         (clk),
   .arst_n_i    (arst_n_i),
   .credit_cnt  (credit_cnt),
   .out_valid_o (out_valid_o),
   .credit_o    (credit_o)
);

/* rtl/decode_stage.sv */
module decode_stage (
   input  logic                         clk,
   input  logic                         arst_n_i,
   input  logic                         in_valid_i,
   input  or1k_decode_pkg::insn_t       insn_i,
   output logic                         credit_o,
   output logic                         out_valid_o,
   output or1k_decode_pkg::decode_out_t out_o,
   input  logic                         credit_i
);

   or1k_decode_pkg::insn_t       entry_insn;
   or1k_decode_pkg::op_flags_t   flags;
   or1k_decode_pkg::alu_opc_t    alu_opc;
   or1k_decode_pkg::rf_addr_t    rfd;
   or1k_decode_pkg::rf_addr_t    rfa;
   or1k_decode_pkg::rf_addr_t    rfb;
   or1k_decode_pkg::imm_t        imm;
   or1k_decode_pkg::except_t     exc;
   or1k_decode_pkg::decode_out_t result;

   decode_ctrl i_decode_ctrl (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .in_valid_i   (in_valid_i),
      .insn_i       (insn_i),
      .credit_i     (credit_i),
      .result_i     (result),
      .entry_insn_o (entry_insn),
      .credit_o     (credit_o),
      .out_valid_o  (out_valid_o),
      .out_o        (out_o)
   );

   op_class_decode i_op_class_decode (
      .insn_i    (entry_insn),
      .flags_o   (flags),
      .alu_opc_o (alu_opc),
      .rfd_o     (rfd),
      .rfa_o     (rfa),
      .rfb_o     (rfb)
   );

   imm_gen i_imm_gen (
      .insn_i (entry_insn),
      .imm_o  (imm)
   );

   illegal_check i_illegal_check (
      .insn_i   (entry_insn),
      .except_o (exc)
   );

   // Bundle the decoded fields of the entry
   always_comb begin
      result.flags   = flags;
      result.alu_opc = alu_opc;
      result.rfd     = rfd;
      result.rfa     = rfa;
      result.rfb     = rfb;
      result.imm     = imm;
      result.exc     = exc;
      result.opcode  = entry_insn[31:26];
   end

endmodule

/* rtl/decode_ctrl.sv */
module decode_ctrl (
   input  logic                         clk,
   input  logic                         arst_n_i,
   input  logic                         in_valid_i,
   input  or1k_decode_pkg::insn_t       insn_i,
   input  logic                         credit_i,
   input  or1k_decode_pkg::decode_out_t result_i,
   output or1k_decode_pkg::insn_t       entry_insn_o,
   output logic                         credit_o,
   output logic                         out_valid_o,
   output or1k_decode_pkg::decode_out_t out_o
);

   logic                         entry_full;
   or1k_decode_pkg::insn_t       entry_insn;
   or1k_decode_pkg::credit_cnt_t credit_cnt;
   logic                         send;
   logic                         sent_q;
   or1k_decode_pkg::decode_out_t out_q;

   // Entry leaves only when downstream has room
   assign send = entry_full && (credit_cnt != '0);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         entry_full <= 1'b0;
      end else begin
         entry_full <= in_valid_i || (entry_full && !send);
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid_i) begin
         entry_insn <= insn_i;
      end
   end

   // Spend on send, refill on credit_i; both at once cancel
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credit_cnt <= or1k_decode_pkg::credit_cnt_t'(or1k_decode_pkg::DS_CREDITS);
      end else if (send && !credit_i) begin
         credit_cnt <= credit_cnt - 3'd1;
      end else if (!send && credit_i) begin
         credit_cnt <= credit_cnt + 3'd1;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sent_q <= 1'b0;
      end else begin
         sent_q <= send;
      end
   end

   always_ff @(posedge clk) begin
      if (send) begin
         out_q <= result_i;
      end
   end

   assign entry_insn_o = entry_insn;
   assign out_o        = out_q;
   // Emptied entry hands the credit back to fetch
   assign out_valid_o  = sent_q;
   assign credit_o     = sent_q;

endmodule

/* rtl/illegal_check.sv */
module illegal_check (
   input  or1k_decode_pkg::insn_t   insn_i,
   output or1k_decode_pkg::except_t except_o
);

   or1k_decode_pkg::opcode_t  opc;
   or1k_decode_pkg::alu_opc_t minor;
   logic [4:0]                sys_opc;
   logic                      shrt_ok;
   logic                      sys_ok;

   assign opc     = insn_i[31:26];
   assign minor   = insn_i[3:0];
   assign sys_opc = insn_i[25:21];

   // Rotate is not built
   always_comb begin
      case (insn_i[7:6])
         or1k_decode_pkg::SHRT_SLL,
         or1k_decode_pkg::SHRT_SRL,
         or1k_decode_pkg::SHRT_SRA: shrt_ok = 1'b1;
         or1k_decode_pkg::SHRT_ROR: shrt_ok = 1'b0;
         default:                   shrt_ok = 1'b0;
      endcase
   end

   assign except_o.syscall = (opc == or1k_decode_pkg::OPC_SYSTRAPSYNC) &&
                             (sys_opc == or1k_decode_pkg::SYS_SYSCALL);
   assign except_o.trap    = (opc == or1k_decode_pkg::OPC_SYSTRAPSYNC) &&
                             (sys_opc == or1k_decode_pkg::SYS_TRAP);
   assign sys_ok = except_o.syscall || except_o.trap ||
                   (sys_opc == or1k_decode_pkg::SYS_MSYNC);

   always_comb begin
      case (opc)
         or1k_decode_pkg::OPC_J, or1k_decode_pkg::OPC_JAL,
         or1k_decode_pkg::OPC_BNF, or1k_decode_pkg::OPC_BF,
         or1k_decode_pkg::OPC_NOP, or1k_decode_pkg::OPC_MOVHI,
         or1k_decode_pkg::OPC_RFE, or1k_decode_pkg::OPC_JR,
         or1k_decode_pkg::OPC_JALR, or1k_decode_pkg::OPC_LWA,
         or1k_decode_pkg::OPC_LWZ, or1k_decode_pkg::OPC_LWS,
         or1k_decode_pkg::OPC_LBZ, or1k_decode_pkg::OPC_LBS,
         or1k_decode_pkg::OPC_LHZ, or1k_decode_pkg::OPC_LHS,
         or1k_decode_pkg::OPC_ADDI, or1k_decode_pkg::OPC_ANDI,
         or1k_decode_pkg::OPC_ORI, or1k_decode_pkg::OPC_XORI,
         or1k_decode_pkg::OPC_MULI, or1k_decode_pkg::OPC_MFSPR,
         or1k_decode_pkg::OPC_SFIMM, or1k_decode_pkg::OPC_MTSPR,
         or1k_decode_pkg::OPC_SWA, or1k_decode_pkg::OPC_SW,
         or1k_decode_pkg::OPC_SB, or1k_decode_pkg::OPC_SH,
         or1k_decode_pkg::OPC_SF:
            except_o.illegal = 1'b0;
         or1k_decode_pkg::OPC_SHRTI:
            except_o.illegal = !shrt_ok;
         or1k_decode_pkg::OPC_ALU: begin
            case (minor)
               or1k_decode_pkg::ALU_ADD, or1k_decode_pkg::ALU_SUB,
               or1k_decode_pkg::ALU_AND, or1k_decode_pkg::ALU_OR,
               or1k_decode_pkg::ALU_XOR, or1k_decode_pkg::ALU_MUL,
               or1k_decode_pkg::ALU_MULU:
                  except_o.illegal = 1'b0;
               or1k_decode_pkg::ALU_SHRT:
                  except_o.illegal = !shrt_ok;
               // No divider, carry, extend, cmov or ff1 in this core
               or1k_decode_pkg::ALU_ADDC, or1k_decode_pkg::ALU_DIV,
               or1k_decode_pkg::ALU_DIVU, or1k_decode_pkg::ALU_EXTBH,
               or1k_decode_pkg::ALU_EXTW, or1k_decode_pkg::ALU_CMOV,
               or1k_decode_pkg::ALU_FFL1:
                  except_o.illegal = 1'b1;
               default:
                  except_o.illegal = 1'b1;
            endcase
         end
         or1k_decode_pkg::OPC_SYSTRAPSYNC:
            except_o.illegal = !sys_ok;
         default:
            except_o.illegal = 1'b1;
      endcase
   end

endmodule

/* rtl/imm_gen.sv */
module imm_gen (
   input  or1k_decode_pkg::insn_t insn_i,
   output or1k_decode_pkg::imm_t  imm_o
);

   or1k_decode_pkg::opcode_t opc;
   logic                     is_store;
   logic                     split;
   logic [15:0]              imm16;
   logic                     sext_sel;
   logic                     zext_sel;
   logic                     high_sel;

   assign opc = insn_i[31:26];

   assign is_store = (opc == or1k_decode_pkg::OPC_SW) || (opc == or1k_decode_pkg::OPC_SB) ||
                     (opc == or1k_decode_pkg::OPC_SH) || (opc == or1k_decode_pkg::OPC_SWA);

   // Stores and mtspr carry rD bits as the top of the immediate
   assign split = is_store || (opc == or1k_decode_pkg::OPC_MTSPR);
   assign imm16 = split ? {insn_i[25:21], insn_i[10:0]} : insn_i[15:0];

   assign sext_sel = ((opc[5:4] == 2'b10) && (opc != or1k_decode_pkg::OPC_ORI) &&
                      (opc != or1k_decode_pkg::OPC_ANDI)) ||
                     is_store || (opc == or1k_decode_pkg::OPC_LWA);
   assign zext_sel = (opc == or1k_decode_pkg::OPC_ORI) || (opc == or1k_decode_pkg::OPC_ANDI) ||
                     (opc == or1k_decode_pkg::OPC_MTSPR);
   assign high_sel = (opc == or1k_decode_pkg::OPC_MOVHI);

   assign imm_o.value = sext_sel ? {{16{imm16[15]}}, imm16} :
                        zext_sel ? {16'd0, imm16} : {imm16, 16'd0};
   assign imm_o.sel   = sext_sel || zext_sel || high_sel;

endmodule

/* rtl/op_class_decode.sv */
module op_class_decode (
   input  or1k_decode_pkg::insn_t     insn_i,
   output or1k_decode_pkg::op_flags_t flags_o,
   output or1k_decode_pkg::alu_opc_t  alu_opc_o,
   output or1k_decode_pkg::rf_addr_t  rfd_o,
   output or1k_decode_pkg::rf_addr_t  rfa_o,
   output or1k_decode_pkg::rf_addr_t  rfb_o
);

   or1k_decode_pkg::opcode_t  opc;
   or1k_decode_pkg::alu_opc_t minor;
   logic                      is_alu_opc;

   assign opc        = insn_i[31:26];
   assign minor      = insn_i[3:0];
   assign is_alu_opc = (opc == or1k_decode_pkg::OPC_ALU);

   always_comb begin
      flags_o = '0;

      // Loads sit in one contiguous block, LWA lives elsewhere
      flags_o.load = ((opc >= or1k_decode_pkg::OPC_LWZ) && (opc <= or1k_decode_pkg::OPC_LHS)) ||
                     (opc == or1k_decode_pkg::OPC_LWA);
      flags_o.store = (opc == or1k_decode_pkg::OPC_SW) || (opc == or1k_decode_pkg::OPC_SB) ||
                      (opc == or1k_decode_pkg::OPC_SH) || (opc == or1k_decode_pkg::OPC_SWA);
      flags_o.atomic = (opc == or1k_decode_pkg::OPC_LWA) || (opc == or1k_decode_pkg::OPC_SWA);

      case (opc)
         or1k_decode_pkg::OPC_SB, or1k_decode_pkg::OPC_LBZ, or1k_decode_pkg::OPC_LBS:
            flags_o.lsu_len = or1k_decode_pkg::LSU_BYTE;
         or1k_decode_pkg::OPC_SH, or1k_decode_pkg::OPC_LHZ, or1k_decode_pkg::OPC_LHS:
            flags_o.lsu_len = or1k_decode_pkg::LSU_HALF;
         default:
            flags_o.lsu_len = or1k_decode_pkg::LSU_WORD;
      endcase
      flags_o.lsu_zext = opc[0];

      // Immediate jumps and branches are the lowest opcodes
      flags_o.jbr    = (opc < or1k_decode_pkg::OPC_NOP);
      flags_o.jr     = (opc == or1k_decode_pkg::OPC_JR) || (opc == or1k_decode_pkg::OPC_JALR);
      flags_o.jal    = (opc == or1k_decode_pkg::OPC_JAL) || (opc == or1k_decode_pkg::OPC_JALR);
      flags_o.bf     = (opc == or1k_decode_pkg::OPC_BF);
      flags_o.bnf    = (opc == or1k_decode_pkg::OPC_BNF);
      flags_o.branch = flags_o.jbr || flags_o.jr || flags_o.jal;

      flags_o.alu = is_alu_opc || (opc == or1k_decode_pkg::OPC_ORI) ||
                    (opc == or1k_decode_pkg::OPC_ANDI) || (opc == or1k_decode_pkg::OPC_XORI);
      flags_o.setflag = (opc == or1k_decode_pkg::OPC_SF) || (opc == or1k_decode_pkg::OPC_SFIMM);
      flags_o.mul = (is_alu_opc && ((minor == or1k_decode_pkg::ALU_MUL) ||
                                    (minor == or1k_decode_pkg::ALU_MULU))) ||
                    (opc == or1k_decode_pkg::OPC_MULI);
      flags_o.div = is_alu_opc && ((minor == or1k_decode_pkg::ALU_DIV) ||
                                   (minor == or1k_decode_pkg::ALU_DIVU));
      flags_o.shift = (is_alu_opc && (minor == or1k_decode_pkg::ALU_SHRT)) ||
                      (opc == or1k_decode_pkg::OPC_SHRTI);

      flags_o.movhi = (opc == or1k_decode_pkg::OPC_MOVHI);
      flags_o.mfspr = (opc == or1k_decode_pkg::OPC_MFSPR);
      flags_o.mtspr = (opc == or1k_decode_pkg::OPC_MTSPR);
      flags_o.rfe   = (opc == or1k_decode_pkg::OPC_RFE);

      // Writeback, mostly by opcode group
      flags_o.rf_wb = flags_o.jal || flags_o.movhi || (opc == or1k_decode_pkg::OPC_LWA) ||
                      ((opc[5:4] == 2'b10) && (opc != or1k_decode_pkg::OPC_SFIMM)) ||
                      ((opc[5:4] == 2'b11) && !((opc == or1k_decode_pkg::OPC_SF) ||
                                                flags_o.mtspr || flags_o.store));
   end

   // Logical immediates reuse the register-form ALU op
   always_comb begin
      case (opc)
         or1k_decode_pkg::OPC_ORI:  alu_opc_o = or1k_decode_pkg::ALU_OR;
         or1k_decode_pkg::OPC_ANDI: alu_opc_o = or1k_decode_pkg::ALU_AND;
         or1k_decode_pkg::OPC_XORI: alu_opc_o = or1k_decode_pkg::ALU_XOR;
         default:                   alu_opc_o = minor;
      endcase
   end

   assign rfd_o = flags_o.jal ? or1k_decode_pkg::LINK_REG : insn_i[25:21];
   assign rfa_o = insn_i[20:16];
   assign rfb_o = insn_i[15:11];

endmodule

/* rtl/or1k_decode_pkg.sv */
package or1k_decode_pkg;

   // Plain vector types
   typedef logic [31:0] insn_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [3:0]  alu_opc_t;
   typedef logic [4:0]  rf_addr_t;
   typedef logic [31:0] operand_t;
   typedef logic [1:0]  lsu_len_t;
   typedef logic [2:0]  credit_cnt_t;

   // Major opcodes, bits 31:26
   localparam opcode_t OPC_J           = 6'h00;
   localparam opcode_t OPC_JAL         = 6'h01;
   localparam opcode_t OPC_BNF         = 6'h03;
   localparam opcode_t OPC_BF          = 6'h04;
   localparam opcode_t OPC_NOP         = 6'h05;
   localparam opcode_t OPC_MOVHI       = 6'h06;
   localparam opcode_t OPC_SYSTRAPSYNC = 6'h08;
   localparam opcode_t OPC_RFE         = 6'h09;
   localparam opcode_t OPC_JR          = 6'h11;
   localparam opcode_t OPC_JALR        = 6'h12;
   localparam opcode_t OPC_LWA         = 6'h1b;
   localparam opcode_t OPC_LWZ         = 6'h21;
   localparam opcode_t OPC_LWS         = 6'h22;
   localparam opcode_t OPC_LBZ         = 6'h23;
   localparam opcode_t OPC_LBS         = 6'h24;
   localparam opcode_t OPC_LHZ         = 6'h25;
   localparam opcode_t OPC_LHS         = 6'h26;
   localparam opcode_t OPC_ADDI        = 6'h27;
   localparam opcode_t OPC_ANDI        = 6'h29;
   localparam opcode_t OPC_ORI         = 6'h2a;
   localparam opcode_t OPC_XORI        = 6'h2b;
   localparam opcode_t OPC_MULI        = 6'h2c;
   localparam opcode_t OPC_MFSPR       = 6'h2d;
   localparam opcode_t OPC_SHRTI       = 6'h2e;
   localparam opcode_t OPC_SFIMM       = 6'h2f;
   localparam opcode_t OPC_MTSPR       = 6'h30;
   localparam opcode_t OPC_SWA         = 6'h33;
   localparam opcode_t OPC_SW          = 6'h35;
   localparam opcode_t OPC_SB          = 6'h36;
   localparam opcode_t OPC_SH          = 6'h37;
   localparam opcode_t OPC_ALU         = 6'h38;
   localparam opcode_t OPC_SF          = 6'h39;

   // ALU minor opcodes, bits 3:0
   localparam alu_opc_t ALU_ADD   = 4'h0;
   localparam alu_opc_t ALU_ADDC  = 4'h1;
   localparam alu_opc_t ALU_SUB   = 4'h2;
   localparam alu_opc_t ALU_AND   = 4'h3;
   localparam alu_opc_t ALU_OR    = 4'h4;
   localparam alu_opc_t ALU_XOR   = 4'h5;
   localparam alu_opc_t ALU_MUL   = 4'h6;
   localparam alu_opc_t ALU_SHRT  = 4'h8;
   localparam alu_opc_t ALU_DIV   = 4'h9;
   localparam alu_opc_t ALU_DIVU  = 4'ha;
   localparam alu_opc_t ALU_MULU  = 4'hb;
   localparam alu_opc_t ALU_EXTBH = 4'hc;
   localparam alu_opc_t ALU_EXTW  = 4'hd;
   localparam alu_opc_t ALU_CMOV  = 4'he;
   localparam alu_opc_t ALU_FFL1  = 4'hf;

   // Shift kind, bits 7:6
   localparam logic [1:0] SHRT_SLL = 2'h0;
   localparam logic [1:0] SHRT_SRL = 2'h1;
   localparam logic [1:0] SHRT_SRA = 2'h2;
   localparam logic [1:0] SHRT_ROR = 2'h3;

   // SYSTRAPSYNC sub-opcodes, bits 25:21
   localparam logic [4:0] SYS_SYSCALL = 5'h00;
   localparam logic [4:0] SYS_TRAP    = 5'h08;
   localparam logic [4:0] SYS_MSYNC   = 5'h10;

   // Access length codes
   localparam lsu_len_t LSU_BYTE = 2'b00;
   localparam lsu_len_t LSU_HALF = 2'b01;
   localparam lsu_len_t LSU_WORD = 2'b10;

   localparam rf_addr_t LINK_REG   = 5'd9;
   localparam int       DS_CREDITS = 4;

   typedef struct packed {
      logic     load;
      logic     store;
      logic     atomic;
      logic     jbr;
      logic     jr;
      logic     jal;
      logic     bf;
      logic     bnf;
      logic     branch;
      logic     alu;
      logic     setflag;
      logic     mul;
      logic     div;
      logic     shift;
      logic     movhi;
      logic     mfspr;
      logic     mtspr;
      logic     rfe;
      logic     rf_wb;
      logic     lsu_zext;
      lsu_len_t lsu_len;
   } op_flags_t;

   typedef struct packed {
      operand_t value;
      logic     sel;
   } imm_t;

   typedef struct packed {
      logic illegal;
      logic syscall;
      logic trap;
   } except_t;

   typedef struct packed {
      op_flags_t flags;
      alu_opc_t  alu_opc;
      rf_addr_t  rfd;
      rf_addr_t  rfa;
      rf_addr_t  rfb;
      imm_t      imm;
      except_t   exc;
      opcode_t   opcode;
   } decode_out_t;

endpackage
